/* Makefile */
# Verilator build and run of the tagger testbench
VERILATOR ?= verilator
TOP       ?= tb_tagger_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/channel_stats.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tagger_defines.svh"

module channel_stats (
   input  wire logic                  sys_clk,
   input  wire logic                  sys_clk_rst,
   input  wire tagger_pkg::tag_word_t tags_i,
   input  wire tagger_pkg::wb_req_t   wb_req_i,
   output tagger_pkg::wb_rsp_t        wb_rsp_o
);

   import tagger_pkg::*;

   // Counter index is edge * channels + |ch| - 1
   localparam int NUM_IDX = 2 * `NUM_CHANNELS;
   localparam int IDX_BITS = $clog2(NUM_IDX);
   // Up to all lanes may hit one index in a word
   localparam int INC_BITS = $clog2(`TAG_LANES + 1);
   // Register map with counters first and timestamp pairs after
   localparam int REG_BITS = `SLAVE_SEL_LSB;
   localparam int TS_BASE = NUM_IDX;
   localparam int OOR_REG = TS_BASE + 2 * NUM_IDX;
   localparam int WRAP_REG = OOR_REG + 1;

   // Statistics registers
   logic [31:0]           evt_cnt [NUM_IDX];
   logic [63:0]           last_ts [NUM_IDX];
   logic [31:0]           oor_cnt;
   logic [31:0]           wrap_cnt;

   // Per-word summary with one update per index
   logic [INC_BITS-1:0]   hit_cnt [NUM_IDX];
   logic [63:0]           hit_ts [NUM_IDX];
   logic [INC_BITS-1:0]   oor_inc;
   logic [INC_BITS-1:0]   wrap_inc;

   // Lane classification scratch
   logic                  lane_neg;
   logic [`CHAN_BITS-1:0] lane_abs;
   logic [IDX_BITS-1:0]   lane_idx;

   // Bus side
   logic [REG_BITS-1:0]   reg_idx;
   logic [REG_BITS-1:0]   rd_off;
   logic [31:0]           rd_dat;
   logic                  ack_q;
   logic [31:0]           dat_q;
   logic                  access;
   logic                  clear;

   // Fold the lanes of one word into per-index increments
   always_comb begin
      for (int i = 0; i < NUM_IDX; i++) begin
         hit_cnt[i] = '0;
         hit_ts[i] = '0;
      end
      oor_inc = '0;
      wrap_inc = '0;
      lane_neg = 1'b0;
      lane_abs = '0;
      lane_idx = '0;
      for (int k = 0; k < `TAG_LANES; k++) begin
         // Negative channel is a falling edge
         lane_neg = tags_i[k].channel[`CHAN_BITS-1];
         lane_abs = tags_i[k].channel;
         if (lane_neg) begin
            lane_abs = ~lane_abs + 1'b1;
         end
         lane_idx = IDX_BITS'(lane_abs - 1'b1);
         if (lane_neg) begin
            lane_idx = lane_idx + IDX_BITS'(`NUM_CHANNELS);
         end
         if (tags_i[k].valid) begin
            if (tags_i[k].kind == TAG_WRAP) begin
               wrap_inc = wrap_inc + 1'b1;
            end else if (lane_abs <= `NUM_CHANNELS) begin
               hit_cnt[lane_idx] = hit_cnt[lane_idx] + 1'b1;
               // Later lanes overwrite so the highest lane wins
               hit_ts[lane_idx] = tags_i[k].timestamp;
            end else begin
               oor_inc = oor_inc + 1'b1;
            end
         end
      end
   end

   // Register index within this slave
   assign reg_idx = wb_req_i.adr[REG_BITS-1:0];
   // New transfer but not the idle cycle after an ack
   assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
   assign clear = access & wb_req_i.we & (reg_idx == REG_BITS'(`STATS_CLEAR_REG));

   // Counter update where a clear wins over same-cycle events
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst || clear) begin
         for (int i = 0; i < NUM_IDX; i++) begin
            evt_cnt[i] <= '0;
            last_ts[i] <= '0;
         end
         oor_cnt <= '0;
         wrap_cnt <= '0;
      end else begin
         for (int i = 0; i < NUM_IDX; i++) begin
            evt_cnt[i] <= evt_cnt[i] + hit_cnt[i];
            if (hit_cnt[i] != '0) begin
               last_ts[i] <= hit_ts[i];
            end
         end
         oor_cnt <= oor_cnt + oor_inc;
         wrap_cnt <= wrap_cnt + wrap_inc;
      end
   end

   // Read mux
   // Timestamp pair i sits at TS_BASE + 2i (low) and TS_BASE + 2i + 1 (high)
   always_comb begin
      rd_off = reg_idx - REG_BITS'(TS_BASE);
      rd_dat = '0;
      if (reg_idx < REG_BITS'(TS_BASE)) begin
         rd_dat = evt_cnt[reg_idx[IDX_BITS-1:0]];
      end else if (reg_idx < REG_BITS'(OOR_REG)) begin
         if (rd_off[0]) begin
            rd_dat = last_ts[rd_off[IDX_BITS:1]][63:32];
         end else begin
            rd_dat = last_ts[rd_off[IDX_BITS:1]][31:0];
         end
      end else if (reg_idx == REG_BITS'(OOR_REG)) begin
         rd_dat = oor_cnt;
      end else if (reg_idx == REG_BITS'(WRAP_REG)) begin
         rd_dat = wrap_cnt;
      end
   end

   // One-cycle ack that stays low for a cycle afterwards
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge sys_clk) begin
      dat_q <= rd_dat;
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = dat_q;

endmodule

`default_nettype wire

/* hdl/tag_converter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tagger_defines.svh"

module tag_converter (
   input  wire logic                               sys_clk,
   input  wire logic                               sys_clk_rst,
   input  wire logic                               tag_valid_i,
   input  wire logic [`TAG_LANES*`TAG_BITS-1:0]    tag_data_i,
   input  wire logic [`TAG_LANES-1:0]              tag_keep_i,
   output tagger_pkg::tag_word_t                   tags_o
);

   import tagger_pkg::*;

   // Upper timestamp bits come from the wrap count
   localparam int WRAP_BITS = 64 - `SUBTIME_BITS;

   // Wraps seen so far, before the current word
   logic [WRAP_BITS-1:0]     wrap_cnt;
   // Running count while walking the lanes
   logic [WRAP_BITS-1:0]     wrap_run;

   // Per-lane fields of the current word
   logic [`CHAN_BITS-1:0]    lane_chan;
   logic [`SUBTIME_BITS-1:0] lane_sub;
   logic                     lane_kept;

   // Decoded word before the output register
   tag_word_t                tags_d;

   // Output register, valid flags kept apart from the payload
   logic [`TAG_LANES-1:0]    valid_q;
   tag_word_t                payload_q;

   // Lane decode with a running prefix of wraps
   // Lane k sees every wrap in lanes 0..k-1 already counted
   always_comb begin
      wrap_run = wrap_cnt;
      lane_chan = '0;
      lane_sub = '0;
      lane_kept = 1'b0;
      for (int k = 0; k < `TAG_LANES; k++) begin
         lane_chan = tag_data_i[k*`TAG_BITS+`SUBTIME_BITS +: `CHAN_BITS];
         lane_sub = tag_data_i[k*`TAG_BITS +: `SUBTIME_BITS];
         // Dropped keep bit means the lane is ignored entirely
         lane_kept = tag_valid_i & tag_keep_i[k];
         tags_d[k].valid = lane_kept;
         tags_d[k].channel = lane_chan;
         if (lane_chan == '0) begin
            tags_d[k].kind = TAG_WRAP;
            // A kept wrap bumps the count for itself and all lanes above
            if (lane_kept) begin
               wrap_run = wrap_run + WRAP_BITS'(1);
            end
         end else begin
            tags_d[k].kind = TAG_EVENT;
         end
         // Wrap count shifted above the subtime
         tags_d[k].timestamp = {wrap_run, lane_sub};
      end
   end

   // Control state, wrap count and lane valids
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         wrap_cnt <= '0;
         valid_q <= '0;
      end else begin
         wrap_cnt <= wrap_run;
         for (int k = 0; k < `TAG_LANES; k++) begin
            valid_q[k] <= tags_d[k].valid;
         end
      end
   end

   // Lane payload, a new word every cycle
   always_ff @(posedge sys_clk) begin
      payload_q <= tags_d;
   end

   // Merge valids back into the records
   always_comb begin
      tags_o = payload_q;
      for (int k = 0; k < `TAG_LANES; k++) begin
         tags_o[k].valid = valid_q[k];
      end
   end

endmodule

`default_nettype wire

/* hdl/tagger_defines.svh */
`ifndef TAGGER_DEFINES_SVH
`define TAGGER_DEFINES_SVH

// Stream word layout
`define TAG_LANES 4
`define TAG_BITS 32
// Raw tag fields, channel sits above the subtime
`define SUBTIME_BITS 26
`define CHAN_BITS 6

// Channels counted per edge
`define NUM_CHANNELS 8

// Wishbone port
`define WB_ADR_BITS 12
`define WB_DAT_BITS 32
// Address bits at and above this one select the slave
`define SLAVE_SEL_LSB 8

// Identification and statistics register map
`define DESIGN_VERSION 1
`define STATS_CLEAR_REG 63

`endif

/* hdl/tagger_pkg.sv */
`default_nettype none

`include "tagger_defines.svh"

package tagger_pkg;

   // Kind of a decoded lane, channel 0 means wrap
   typedef enum logic {
      TAG_EVENT,
      TAG_WRAP
   } tag_kind_e;

   // One decoded lane
   typedef struct packed {
      logic                         valid;
      tag_kind_e                    kind;
      logic signed [`CHAN_BITS-1:0] channel;
      logic [63:0]                  timestamp;
   } tag_rec_t;

   // All lanes of one stream word, lane 0 at the bottom
   typedef tag_rec_t [`TAG_LANES-1:0] tag_word_t;

   // Wishbone classic request from the master
   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [`WB_ADR_BITS-1:0] adr;
      logic [`WB_DAT_BITS-1:0] dat;
   } wb_req_t;

   // Wishbone classic response from a slave
   typedef struct packed {
      logic                    ack;
      logic [`WB_DAT_BITS-1:0] dat;
   } wb_rsp_t;

   // Slave selected by the upper address nibble
   typedef enum logic [3:0] {
      SLV_ID    = 4'd0,
      SLV_STATS = 4'd1
   } wb_slave_e;

endpackage

`default_nettype wire

/* hdl/tagger_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tagger_defines.svh"

module tagger_top (
   input  wire logic                            sys_clk,
   input  wire logic                            sys_clk_rst,
   // Tag stream, four lanes per word
   input  wire logic                            tag_valid_i,
   input  wire logic [`TAG_LANES*`TAG_BITS-1:0] tag_data_i,
   input  wire logic [`TAG_LANES-1:0]           tag_keep_i,
   // Wishbone classic slave port
   input  wire tagger_pkg::wb_req_t             wb_req_i,
   output tagger_pkg::wb_rsp_t                  wb_rsp_o
);

   import tagger_pkg::*;

   // Decoded lanes into the statistics
   tag_word_t tags;
   // Bus leg to the statistics slave
   wb_req_t   stats_req;
   wb_rsp_t   stats_rsp;

   // Raw tags to channel and timestamp records
   tag_converter i_tag_converter (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .tag_valid_i (tag_valid_i),
      .tag_data_i  (tag_data_i),
      .tag_keep_i  (tag_keep_i),
      .tags_o      (tags)
   );

   // Per-channel counters and last timestamps
   channel_stats i_channel_stats (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .tags_i      (tags),
      .wb_req_i    (stats_req),
      .wb_rsp_o    (stats_rsp)
   );

   // Address decode, ID block and response mux
   wb_decoder i_wb_decoder (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .wb_req_i    (wb_req_i),
      .wb_rsp_o    (wb_rsp_o),
      .stats_req_o (stats_req),
      .stats_rsp_i (stats_rsp)
   );

endmodule

`default_nettype wire

/* hdl/wb_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tagger_defines.svh"

module wb_decoder (
   input  wire logic                sys_clk,
   input  wire logic                sys_clk_rst,
   input  wire tagger_pkg::wb_req_t wb_req_i,
   output tagger_pkg::wb_rsp_t      wb_rsp_o,
   output tagger_pkg::wb_req_t      stats_req_o,
   input  wire tagger_pkg::wb_rsp_t stats_rsp_i
);

   import tagger_pkg::*;

   // Slave chosen by the upper address bits
   wb_slave_e                 slave_sel;
   // Register index inside a slave
   logic [`SLAVE_SEL_LSB-1:0] reg_idx;

   // Local slave covers the ID block and every unmapped address
   logic                      local_sel;
   logic                      id_ack_q;
   logic [`WB_DAT_BITS-1:0]   id_dat;
   logic [`WB_DAT_BITS-1:0]   id_dat_q;

   // Out-of-range nibbles stay outside the enum and land in default
   assign slave_sel = wb_slave_e'(wb_req_i.adr[`WB_ADR_BITS-1:`SLAVE_SEL_LSB]);
   assign reg_idx = wb_req_i.adr[`SLAVE_SEL_LSB-1:0];
   assign local_sel = (slave_sel != SLV_STATS);

   // Statistics slave sees stb only when addressed
   always_comb begin
      stats_req_o = wb_req_i;
      stats_req_o.stb = wb_req_i.stb & (slave_sel == SLV_STATS);
   end

   // ID registers, unmapped slaves read 0
   always_comb begin
      id_dat = '0;
      if (slave_sel == SLV_ID) begin
         case (reg_idx)
            `SLAVE_SEL_LSB'(0): id_dat = `WB_DAT_BITS'(`DESIGN_VERSION);
            `SLAVE_SEL_LSB'(1): id_dat = `WB_DAT_BITS'(`NUM_CHANNELS);
            default: id_dat = '0;
         endcase
      end
   end

   // Local ack, one cycle high then one cycle low
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         id_ack_q <= 1'b0;
      end else begin
         id_ack_q <= wb_req_i.cyc & wb_req_i.stb & local_sel & ~id_ack_q;
      end
   end

   always_ff @(posedge sys_clk) begin
      id_dat_q <= id_dat;
   end

   // Response back to the port
   // Master holds adr until ack, so the select is still valid here
   always_comb begin
      case (slave_sel)
         SLV_STATS: wb_rsp_o = stats_rsp_i;
         default: begin
            wb_rsp_o.ack = id_ack_q;
            wb_rsp_o.dat = id_dat_q;
         end
      endcase
   end

endmodule

`default_nettype wire

/* tests/tagger_tb_util.svh */
`ifndef TAGGER_TB_UTIL_SVH
`define TAGGER_TB_UTIL_SVH

// Statistics register map as seen on the bus
localparam int NUM_IDX = 2 * `NUM_CHANNELS;
localparam int TS_IDX = NUM_IDX;
localparam int OOR_IDX = TS_IDX + 2 * NUM_IDX;
localparam int WRAP_IDX = OOR_IDX + 1;
localparam int WRAP_W = 64 - `SUBTIME_BITS;

// Galois LFSR, shifts right, feedback mask for x^32+x^31+x^29+x+1
logic [31:0] lfsr_state = 32'hcf8e5516;

// Model of the converter wrap count and of every statistics register
logic [WRAP_W-1:0] model_wrap;
logic [31:0]       model_cnt [NUM_IDX];
logic [63:0]       model_ts [NUM_IDX];
logic [31:0]       model_oor;
logic [31:0]       model_wraps;

function automatic void lfsr_step();
   if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'hd000_0001;
   end else begin
      lfsr_state = lfsr_state >> 1;
   end
endfunction

// One LFSR step per bit, bits enter at the bottom
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int b = 0; b < n; b++) begin
      lfsr_step();
      r = {r[30:0], lfsr_state[0]};
   end
   return r;
endfunction

// Statistics only, the wrap count inside the converter keeps running
function automatic void model_clear();
   for (int i = 0; i < NUM_IDX; i++) begin
      model_cnt[i] = '0;
      model_ts[i] = '0;
   end
   model_oor = '0;
   model_wraps = '0;
endfunction

// Apply one accepted stream word, lanes from 0 up
function automatic void model_word(input logic [`TAG_LANES*`TAG_BITS-1:0] data,
                                   input logic [`TAG_LANES-1:0] keep);
   logic signed [`CHAN_BITS-1:0] ch;
   logic [`SUBTIME_BITS-1:0]     sub;
   int                           chi;
   int                           abs_ch;
   int                           idx;
   for (int k = 0; k < `TAG_LANES; k++) begin
      ch = data[k*`TAG_BITS+`SUBTIME_BITS +: `CHAN_BITS];
      sub = data[k*`TAG_BITS +: `SUBTIME_BITS];
      chi = {{(32-`CHAN_BITS){ch[`CHAN_BITS-1]}}, ch};
      abs_ch = (chi < 0) ? -chi : chi;
      // Lanes without keep leave no trace at all
      if (keep[k]) begin
         if (chi == 0) begin
            model_wrap = model_wrap + WRAP_W'(1);
            model_wraps = model_wraps + 32'd1;
         end else if (abs_ch <= `NUM_CHANNELS) begin
            // Falling edges live in the upper half
            idx = ((chi < 0) ? `NUM_CHANNELS : 0) + abs_ch - 1;
            model_cnt[idx] = model_cnt[idx] + 32'd1;
            model_ts[idx] = {model_wrap, sub};
         end else begin
            model_oor = model_oor + 32'd1;
         end
      end
   end
endfunction

// Expected read data of a statistics register index
function automatic logic [31:0] expected_reg(input int idx);
   int ts_i;
   ts_i = (idx - TS_IDX) / 2;
   if (idx < TS_IDX) begin
      return model_cnt[idx];
   end else if (idx < OOR_IDX) begin
      return idx[0] ? model_ts[ts_i][63:32] : model_ts[ts_i][31:0];
   end else if (idx == OOR_IDX) begin
      return model_oor;
   end else if (idx == WRAP_IDX) begin
      return model_wraps;
   end
   return '0;
endfunction

function automatic string reg_name(input int idx);
   if (idx < TS_IDX) begin
      return $sformatf("evt_cnt[%0d]", idx);
   end else if (idx < OOR_IDX) begin
      return $sformatf("last_ts[%0d].%s", (idx - TS_IDX) / 2, idx[0] ? "hi" : "lo");
   end else if (idx == OOR_IDX) begin
      return "oor_cnt";
   end else if (idx == WRAP_IDX) begin
      return "wrap_cnt";
   end
   return $sformatf("stats_reg[%0d]", idx);
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
   if (actual !== expected) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1);
   end
endtask

`endif

/* tests/tb_tagger_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tagger_defines.svh"

module tb_tagger_top;

   import tagger_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int NUM_RANDOM_WORDS = 400;
   localparam int NUM_DIRECTED_WORDS = 8;
   // All-wrap words that push the wrap count past the low timestamp word
   localparam int NUM_WRAP_WORDS = 16;
   // Six full sweeps of 51 registers where a read costs up to 3 cycles
   localparam int NUM_SWEEPS = 6;
   localparam int SWEEP_READS = 51;
   localparam int READ_CYCLES = 3;
   localparam int MAX_CYCLES = 2 * (RESET_CYCLES + NUM_RANDOM_WORDS + 4 * NUM_DIRECTED_WORDS
                               + NUM_WRAP_WORDS + 8 * 4
                               + READ_CYCLES * (NUM_SWEEPS * SWEEP_READS + 8));

   // Slave bases on adr[11:8]
   localparam logic [11:0] ID_BASE = 12'h000;
   localparam logic [11:0] STATS_BASE = 12'h100;
   localparam logic [11:0] UNMAPPED_BASE = 12'h200;

   // Raw channel fields
   localparam logic [5:0] CH_WRAP = 6'd0;
   localparam logic [5:0] CH_RISE1 = 6'd1;
   localparam logic [5:0] CH_RISE3 = 6'd3;
   localparam logic [5:0] CH_RISE7 = 6'd7;
   localparam logic [5:0] CH_FALL2 = 6'(-2);
   localparam logic [5:0] CH_FALL5 = 6'(-5);
   localparam logic [5:0] CH_FALL8 = 6'(-8);
   localparam logic [5:0] CH_OUT20 = 6'd20;

   logic                            sys_clk;
   logic                            sys_clk_rst;
   logic                            tag_valid;
   logic [`TAG_LANES*`TAG_BITS-1:0] tag_data;
   logic [`TAG_LANES-1:0]           tag_keep;
   wb_req_t                         wb_req;
   wb_rsp_t                         wb_rsp;
   int                              cycle_cnt = 0;

   // Reads waiting for the compare process
   string                           name_q[$];
   logic [31:0]                     exp_q[$];
   logic [31:0]                     act_q[$];

   `include "tagger_tb_util.svh"

   tagger_top i_tagger_top (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .tag_valid_i (tag_valid),
      .tag_data_i  (tag_data),
      .tag_keep_i  (tag_keep),
      .wb_req_i    (wb_req),
      .wb_rsp_o    (wb_rsp)
   );

   always #2 sys_clk = ~sys_clk;

   always @(posedge sys_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Checks failed");
         $fatal(1);
      end
   end

   // Compare queued reads that were captured at a falling edge
   always @(negedge sys_clk) begin
      while (exp_q.size() != 0) begin
         check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
      end
   end

   function automatic logic [31:0] tag_of(input logic [5:0] ch, input logic [25:0] sub);
      return {ch, sub};
   endfunction

   // One word per falling edge while valid stays high between calls
   task automatic send_word(input logic [`TAG_LANES*`TAG_BITS-1:0] data,
                            input logic [`TAG_LANES-1:0] keep);
      @(negedge sys_clk);
      tag_valid = 1'b1;
      tag_data = data;
      tag_keep = keep;
      model_word(data, keep);
   endtask

   task automatic send_random_word();
      logic [`TAG_LANES*`TAG_BITS-1:0] data;
      logic [31:0]                     r;
      logic [5:0]                      ch;
      for (int k = 0; k < `TAG_LANES; k++) begin
         // A quarter of the lanes take any channel and the rest stay in -8..8
         r = rand_bits(2);
         if (r[1:0] == 2'd0) begin
            r = rand_bits(6);
         end else begin
            r = rand_bits(5);
            r = (r % 32'd17) - 32'd8;
         end
         ch = r[5:0];
         r = rand_bits(26);
         data[k*`TAG_BITS +: `TAG_BITS] = tag_of(ch, r[25:0]);
      end
      r = rand_bits(4);
      send_word(data, r[3:0]);
   endtask

   // Idle the stream and wait past the two-stage update
   task automatic end_burst();
      @(negedge sys_clk);
      tag_valid = 1'b0;
      tag_data = '0;
      tag_keep = '0;
      repeat (3) @(posedge sys_clk);
   endtask

   task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
      @(negedge sys_clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      // Registered ack is settled at the falling edge
      do begin
         @(negedge sys_clk);
      end while (!wb_rsp.ack);
      rdat = wb_rsp.dat;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we = 1'b0;
   endtask

   task automatic read_reg(input logic [11:0] adr, input string name,
                           input logic [31:0] expected);
      logic [31:0] act;
      bus_access(1'b0, adr, 32'd0, act);
      name_q.push_back(name);
      exp_q.push_back(expected);
      act_q.push_back(act);
   endtask

   // Every statistics register plus one unused index
   task automatic sweep_stats();
      for (int idx = 0; idx <= WRAP_IDX; idx++) begin
         read_reg(STATS_BASE + 12'(idx), reg_name(idx), expected_reg(idx));
      end
      read_reg(STATS_BASE + 12'd62, reg_name(62), expected_reg(62));
   endtask

   initial begin
      logic [31:0] rdat;
      sys_clk = 1'b0;
      sys_clk_rst = 1'b1;
      tag_valid = 1'b0;
      tag_data = '0;
      tag_keep = '0;
      wb_req = '0;
      model_wrap = '0;
      model_clear();
      repeat (RESET_CYCLES) @(negedge sys_clk);
      sys_clk_rst = 1'b0;

      // ID block, an unused ID index and an unmapped slave
      read_reg(ID_BASE, "id_version", 32'(`DESIGN_VERSION));
      read_reg(ID_BASE + 12'd1, "id_channels", 32'(`NUM_CHANNELS));
      read_reg(ID_BASE + 12'd2, "id_unused", 32'd0);
      read_reg(UNMAPPED_BASE, "unmapped", 32'd0);

      // Events on +3 and -5 with junk in the upper lanes that have no keep
      send_word({tag_of(CH_WRAP, 26'h0), tag_of(CH_RISE7, 26'h77),
                 tag_of(CH_FALL5, 26'h2a_0022), tag_of(CH_RISE3, 26'h11_0011)}, 4'b0011);
      send_word({tag_of(CH_RISE7, 26'h99), tag_of(CH_RISE7, 26'h88),
                 tag_of(CH_RISE3, 26'h3c_0044), tag_of(CH_FALL5, 26'h3b_0033)}, 4'b0011);
      end_burst();
      sweep_stats();

      // Carry the wrap count into the high timestamp word
      repeat (NUM_WRAP_WORDS) begin
         send_word({4{tag_of(CH_WRAP, 26'h0)}}, 4'b1111);
      end
      // Wraps between events shift the upper lanes
      send_word({tag_of(CH_WRAP, 26'h0), tag_of(CH_FALL5, 26'h155_5555),
                 tag_of(CH_WRAP, 26'h0), tag_of(CH_RISE3, 26'h0aa_aaaa)}, 4'b1111);
      send_word({tag_of(CH_FALL5, 26'h123_4567), tag_of(CH_RISE3, 26'h076_5432),
                 tag_of(CH_WRAP, 26'h0), tag_of(CH_WRAP, 26'h0)}, 4'b1111);
      end_burst();
      sweep_stats();

      // Random burst of one word per cycle
      repeat (NUM_RANDOM_WORDS) send_random_word();
      end_burst();
      sweep_stats();

      // Same index in several lanes where lane 3 of the second word has no keep
      send_word({tag_of(CH_RISE7, 26'h4), tag_of(CH_RISE7, 26'h3),
                 tag_of(CH_RISE7, 26'h2), tag_of(CH_RISE7, 26'h1)}, 4'b1111);
      send_word({tag_of(CH_FALL2, 26'h3ff_fff0), tag_of(CH_FALL2, 26'h20_0003),
                 tag_of(CH_FALL2, 26'h10_0002), tag_of(CH_FALL2, 26'h1)}, 4'b0111);
      end_burst();
      sweep_stats();

      // Clear and count from zero on top of the running wrap count
      bus_access(1'b1, STATS_BASE + 12'(`STATS_CLEAR_REG), 32'hffff_ffff, rdat);
      model_clear();
      sweep_stats();
      send_word({tag_of(CH_OUT20, 26'h5), tag_of(CH_FALL8, 26'h1ab_cdef),
                 tag_of(CH_WRAP, 26'h0), tag_of(CH_RISE1, 26'h3f0_0001)}, 4'b1111);
      end_burst();
      sweep_stats();

      // Let the compare process drain the queue
      while (exp_q.size() != 0) begin
         @(posedge sys_clk);
      end
      @(posedge sys_clk);
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
+incdir+tests
hdl/tagger_pkg.sv
hdl/tag_converter.sv
hdl/channel_stats.sv
hdl/wb_decoder.sv
hdl/tagger_top.sv
tests/tb_tagger_top.sv
